/* monitor_reporter.f */
common/monitor_pkg.sv
event_scan/event_scanner.sv
src/report_ctrl.sv
intr_fifo/intr_fifo.sv
src/packet_formatter.sv
src/monitor_reporter.sv
sim/clk_gen.sv
sim/monitor_reporter_checker.sv
sim/tb_monitor_reporter.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_monitor_reporter \
    -f monitor_reporter.f \
    -o sim_monitor_reporter

./obj_dir/sim_monitor_reporter +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* sim/tb_monitor_reporter.sv */
module tb_monitor_reporter;
    import monitor_pkg::*;

    // Phases need roughly 1000 cycles, the limit leaves three times that
    localparam int CYCLE_LIMIT = 3000;

    logic                                   aclk;
    logic                                   rst_n;
    logic [MAX_TRANSACTIONS-1:0]            trans_valid;
    logic [MAX_TRANSACTIONS*STATE_W-1:0]    trans_state;
    logic [MAX_TRANSACTIONS*ADDR_WIDTH-1:0] trans_addr;
    logic [MAX_TRANSACTIONS*CHAN_W-1:0]     trans_channel;
    logic [MAX_TRANSACTIONS*CODE_W-1:0]     trans_event_code;
    logic [MAX_TRANSACTIONS-1:0]            timeout_detected;
    logic                                   cfg_error_enable;
    logic                                   cfg_timeout_enable;
    logic                                   cfg_compl_enable;
    logic                                   monbus_ready;
    logic                                   monbus_valid;
    logic [63:0]                            monbus_packet;
    logic [EVT_CNT_W-1:0]                   event_count;
    logic [MAX_TRANSACTIONS-1:0]            event_reported_flags;

    // Model of the reported flags and the push count
    logic [MAX_TRANSACTIONS-1:0] mirror    = '0;
    logic [EVT_CNT_W-1:0]        exp_count = '0;
    logic [63:0]                 exp_pkt;
    int                          exp_slot;
    int                          packets        = 0;
    int                          compare_errors = 0;
    int                          state_errors   = 0;
    int                          cycle_count    = 0;

    // Random source and ready pattern
    logic [31:0] rng          = 32'h31b0;
    logic        ready_random = 1'b0;
    logic        ready_level  = 1'b1;
    int          hold_left    = 0;

    clk_gen u_clk_gen (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    monitor_reporter monitor_reporter_inst (
        .aclk                 (aclk),
        .rst_n                (rst_n),
        .trans_valid          (trans_valid),
        .trans_state          (trans_state),
        .trans_addr           (trans_addr),
        .trans_channel        (trans_channel),
        .trans_event_code     (trans_event_code),
        .timeout_detected     (timeout_detected),
        .cfg_error_enable     (cfg_error_enable),
        .cfg_timeout_enable   (cfg_timeout_enable),
        .cfg_compl_enable     (cfg_compl_enable),
        .monbus_ready         (monbus_ready),
        .monbus_valid         (monbus_valid),
        .monbus_packet        (monbus_packet),
        .event_count          (event_count),
        .event_reported_flags (event_reported_flags)
    );

    bind monitor_reporter monitor_reporter_checker u_checker (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .monbus_valid  (monbus_valid),
        .monbus_ready  (monbus_ready),
        .monbus_packet (monbus_packet),
        .event_count   (event_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output logic [31:0] v);
        rng = lcg_next(rng);
        v = rng;
    endtask

    // Class of one slot: 0 error, 1 timeout, 2 completion, -1 none
    // en bit 0 error, bit 1 timeout, bit 2 completion
    function automatic int event_class(input logic [STATE_W-1:0] st, input logic tmo,
                                       input logic [2:0] en);
        if (st == TRANS_ORPHANED && en[0]) return 0;
        if (st == TRANS_ERROR && !tmo && en[0]) return 0;
        if (st == TRANS_ERROR && tmo && en[1]) return 1;
        if (st == TRANS_COMPLETE && en[2]) return 2;
        return -1;
    endfunction

    // Next expected packet, class first and lowest slot within a class
    function automatic logic [63:0] ref_next_packet(
        input  logic [MAX_TRANSACTIONS-1:0]            vld,
        input  logic [MAX_TRANSACTIONS*STATE_W-1:0]    st,
        input  logic [MAX_TRANSACTIONS*ADDR_WIDTH-1:0] adr,
        input  logic [MAX_TRANSACTIONS*CHAN_W-1:0]     ch,
        input  logic [MAX_TRANSACTIONS*CODE_W-1:0]     cd,
        input  logic [MAX_TRANSACTIONS-1:0]            tmo,
        input  logic [2:0]                             en,
        input  logic [MAX_TRANSACTIONS-1:0]            done,
        output int                                     slot
    );
        logic [63:0]       pkt;
        logic [TYPE_W-1:0] ptype;
        logic [CODE_W-1:0] code;
        int                cls;
        int                c;
        int                i;
        pkt  = '0;
        slot = -1;
        cls  = -1;
        for (c = 0; c < 3; c++) begin
            for (i = 0; i < MAX_TRANSACTIONS; i++) begin
                if (slot < 0 && vld[i] && !done[i] &&
                    event_class(st[i*STATE_W +: STATE_W], tmo[i], en) == c) begin
                    slot = i;
                    cls  = c;
                end
            end
        end
        if (slot >= 0) begin
            ptype = (cls == 0) ? PKT_ERROR : (cls == 1) ? PKT_TIMEOUT : PKT_COMPLETION;
            // Completions carry the fixed code
            code  = (cls == 2) ? EVT_TRANS_COMPLETE : cd[slot*CODE_W +: CODE_W];
            pkt   = {ptype, PROTOCOL_AXI, code, ch[slot*CHAN_W +: CHAN_W], UNIT_ID, AGENT_ID,
                     3'b000, adr[slot*ADDR_WIDTH +: ADDR_WIDTH]};
        end
        return pkt;
    endfunction

    function automatic bit events_pending();
        logic [63:0] pkt;
        int          slot;
        pkt = ref_next_packet(trans_valid, trans_state, trans_addr, trans_channel,
                              trans_event_code, timeout_detected,
                              {cfg_compl_enable, cfg_timeout_enable, cfg_error_enable},
                              mirror, slot);
        return (slot >= 0);
    endfunction

    // Compare every transfer against the model
    always @(posedge aclk) begin
        if (rst_n) begin
            if (monbus_valid && monbus_ready) begin
                packets++;
                exp_pkt = ref_next_packet(trans_valid, trans_state, trans_addr, trans_channel,
                                          trans_event_code, timeout_detected,
                                          {cfg_compl_enable, cfg_timeout_enable,
                                           cfg_error_enable}, mirror, exp_slot);
                assert (exp_slot >= 0) else begin
                    compare_errors++;
                    $display("Packet %h transferred at time %0t with no event pending",
                             monbus_packet, $time);
                end
                if (exp_slot >= 0) begin
                    assert (monbus_packet == exp_pkt) else begin
                        compare_errors++;
                        $display("FAILED time=%0t signal=monbus_packet got=%h expected=%h",
                                 $time, monbus_packet, exp_pkt);
                    end
                    mirror[exp_slot] = 1'b1;
                    exp_count++;
                end
            end
            // Freed slots lose their flag
            mirror = mirror & trans_valid;
        end
    end

    // One negedge step, ready in random stretches when enabled
    task automatic step_cycle();
        logic [31:0] r;
        @(negedge aclk);
        if (ready_random) begin
            if (hold_left == 0) begin
                draw_random(r);
                ready_level = r[31];
                hold_left   = 1 + int'(r[2:0]);
            end
            hold_left--;
            monbus_ready = ready_level;
        end else begin
            monbus_ready = 1'b1;
        end
    endtask

    task automatic settle(input int n);
        repeat (n) begin
            @(negedge aclk);
            monbus_ready = 1'b1;
        end
    endtask

    // Idle state matches the model, nothing extra shows up
    task automatic check_quiet();
        settle(8);
        assert (!monbus_valid) else begin
            state_errors++;
            $display("FAILED time=%0t signal=monbus_valid got=%b expected=0",
                     $time, monbus_valid);
        end
        assert (event_count == exp_count) else begin
            state_errors++;
            $display("FAILED time=%0t signal=event_count got=%0d expected=%0d",
                     $time, event_count, exp_count);
        end
        assert (event_reported_flags == mirror) else begin
            state_errors++;
            $display("FAILED time=%0t signal=event_reported_flags got=%h expected=%h",
                     $time, event_reported_flags, mirror);
        end
    endtask

    task automatic drain_and_check();
        while (monbus_valid || events_pending()) begin
            step_cycle();
        end
        check_quiet();
    endtask

    task automatic clear_table();
        trans_valid = '0;
        check_quiet();
    endtask

    task automatic fill_slot(input int i, input logic vld, input logic [STATE_W-1:0] st,
                             input logic tmo);
        logic [31:0] r;
        draw_random(r);
        trans_valid[i]                        = vld;
        trans_state[i*STATE_W +: STATE_W]     = st;
        timeout_detected[i]                   = tmo;
        trans_addr[i*ADDR_WIDTH +: ADDR_WIDTH] = r;
        draw_random(r);
        trans_channel[i*CHAN_W +: CHAN_W]     = r[13:8];
        trans_event_code[i*CODE_W +: CODE_W]  = r[23:20];
    endtask

    // Every slot random, valid when the draw is below the threshold
    task automatic load_random_table(input logic [7:0] valid_thresh);
        logic [31:0] r;
        int          i;
        for (i = 0; i < MAX_TRANSACTIONS; i++) begin
            draw_random(r);
            fill_slot(i, r[7:0] < valid_thresh, STATE_W'(r[31:16] % 16'd5), r[8]);
        end
    endtask

    task automatic set_enables(input logic [2:0] en);
        cfg_error_enable   = en[0];
        cfg_timeout_enable = en[1];
        cfg_compl_enable   = en[2];
    endtask

    task automatic report_totals();
        $display("Totals: packets=%0d compare_errors=%0d state_errors=%0d assertion_errors=%0d",
                 packets, compare_errors, state_errors,
                 monitor_reporter_inst.u_checker.fail_count);
    endtask

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        report_totals();
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int                   k;
        int                   i;
        logic [2:0]           en;
        logic [EVT_CNT_W-1:0] count_before;
        trans_valid      = '0;
        trans_state      = '0;
        trans_addr       = '0;
        trans_channel    = '0;
        trans_event_code = '0;
        timeout_detected = '0;
        set_enables(3'b111);
        monbus_ready     = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge aclk);

        // Reset state
        assert (!monbus_valid && event_count == '0 && event_reported_flags == '0) else begin
            state_errors++;
            $display("Outputs not cleared after reset at time %0t", $time);
        end

        // Lone completion, one packet only
        fill_slot(5, 1'b1, TRANS_COMPLETE, 1'b0);
        drain_and_check();
        settle(10);
        assert (packets == 1 && event_reported_flags[5]) else begin
            state_errors++;
            $display("FAILED time=%0t signal=transfers got=%0d expected=1", $time, packets);
        end
        clear_table();

        // Hand-made mix of every class plus non-events
        fill_slot(0, 1'b1, TRANS_ACTIVE, 1'b0);
        fill_slot(1, 1'b1, TRANS_COMPLETE, 1'b0);
        fill_slot(2, 1'b1, TRANS_ERROR, 1'b1);
        fill_slot(4, 1'b1, TRANS_ORPHANED, 1'b0);
        fill_slot(6, 1'b1, TRANS_COMPLETE, 1'b1);
        fill_slot(9, 1'b1, TRANS_ERROR, 1'b0);
        fill_slot(12, 1'b1, TRANS_ERROR, 1'b1);
        fill_slot(14, 1'b0, TRANS_ERROR, 1'b0);
        fill_slot(15, 1'b1, TRANS_IDLE, 1'b1);
        drain_and_check();
        clear_table();
        repeat (2) begin
            load_random_table(8'd200);
            drain_and_check();
            clear_table();
        end

        // One class held back, then released
        for (k = 0; k < 3; k++) begin
            en    = 3'b111;
            en[k] = 1'b0;
            set_enables(en);
            load_random_table(8'd255);
            drain_and_check();
            set_enables(3'b111);
            drain_and_check();
            clear_table();
        end

        // Back-pressure deeper than the FIFO
        ready_random = 1'b1;
        repeat (4) begin
            clear_table();
            load_random_table(8'd255);
            drain_and_check();
        end
        ready_random = 1'b0;

        // Reuse of a reported slot
        k = -1;
        for (i = MAX_TRANSACTIONS - 1; i >= 0; i--) begin
            if (mirror[i]) k = i;
        end
        assert (k >= 0) else begin
            state_errors++;
            $display("No reported slot left to reuse at time %0t", $time);
        end
        if (k >= 0) begin
            trans_valid[k] = 1'b0;
            check_quiet();
            assert (!event_reported_flags[k]) else begin
                state_errors++;
                $display("FAILED time=%0t signal=event_reported_flags[%0d] got=1 expected=0",
                         $time, k);
            end
            count_before = exp_count;
            fill_slot(k, 1'b1, TRANS_COMPLETE, 1'b0);
            drain_and_check();
            assert (event_count == count_before + 1'b1) else begin
                state_errors++;
                $display("FAILED time=%0t signal=event_count got=%0d expected=%0d",
                         $time, event_count, count_before + 1'b1);
            end
        end

        report_totals();
        if (compare_errors + state_errors + monitor_reporter_inst.u_checker.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sim/monitor_reporter_checker.sv */
module monitor_reporter_checker (
    input  logic                              aclk,
    input  logic                              rst_n,
    input  logic                              monbus_valid,
    input  logic                              monbus_ready,
    input  logic [63:0]                       monbus_packet,
    input  logic [monitor_pkg::EVT_CNT_W-1:0] event_count
);
    import monitor_pkg::*;

    // Number of assertion failures so far
    int fail_count = 0;

    // Stalled packet holds until the transfer
    a_stall_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        monbus_valid && !monbus_ready |=> monbus_valid && $stable(monbus_packet))
    else begin
        fail_count++;
        $error("monitor bus packet dropped or changed while ready was low");
    end

    // Source fields never vary
    a_fixed_fields: assert property (@(posedge aclk) disable iff (!rst_n)
        monbus_valid |-> monbus_packet[PKT_PROTO_HI:PKT_PROTO_LO] == PROTOCOL_AXI &&
                         monbus_packet[PKT_UNIT_HI:PKT_UNIT_LO] == UNIT_ID &&
                         monbus_packet[PKT_AGENT_HI:PKT_AGENT_LO] == AGENT_ID)
    else begin
        fail_count++;
        $error("protocol, unit or agent field of the packet is wrong");
    end

    // At most one push per cycle, wrap included
    a_count_step: assert property (@(posedge aclk) disable iff (!rst_n)
        event_count == $past(event_count) ||
        event_count == EVT_CNT_W'($past(event_count) + 1'b1))
    else begin
        fail_count++;
        $error("event_count moved by more than one in a cycle");
    end

endmodule

/* sim/clk_gen.sv */
module clk_gen (
    output logic aclk,
    output logic rst_n
);
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 5;

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
    end

endmodule

/* src/monitor_reporter.sv */
module monitor_reporter (
    input  logic                                                            aclk,
    input  logic                                                            rst_n,

    // Outstanding transaction table, one field slice per slot
    input  logic [monitor_pkg::MAX_TRANSACTIONS-1:0]                        trans_valid,
    input  logic [monitor_pkg::MAX_TRANSACTIONS*monitor_pkg::STATE_W-1:0]   trans_state,
    input  logic [monitor_pkg::MAX_TRANSACTIONS*monitor_pkg::ADDR_WIDTH-1:0] trans_addr,
    input  logic [monitor_pkg::MAX_TRANSACTIONS*monitor_pkg::CHAN_W-1:0]    trans_channel,
    input  logic [monitor_pkg::MAX_TRANSACTIONS*monitor_pkg::CODE_W-1:0]    trans_event_code,
    input  logic [monitor_pkg::MAX_TRANSACTIONS-1:0]                        timeout_detected,

    // Per-class report enables
    input  logic                                                            cfg_error_enable,
    input  logic                                                            cfg_timeout_enable,
    input  logic                                                            cfg_compl_enable,

    // Monitor bus
    input  logic                                                            monbus_ready,
    output logic                                                            monbus_valid,
    output logic [63:0]                                                     monbus_packet,

    // Statistics and feedback to the table owner
    output logic [monitor_pkg::EVT_CNT_W-1:0]                               event_count,
    output logic [monitor_pkg::MAX_TRANSACTIONS-1:0]                        event_reported_flags
);
    import monitor_pkg::*;

    // Scanner to control
    logic [MAX_TRANSACTIONS-1:0] snap_valid;
    logic                        cand_valid;
    logic [SLOT_W-1:0]           cand_slot;
    logic [ENTRY_W-1:0]          entry_data;

    // FIFO handshake
    logic                        push;
    logic                        not_full;
    logic                        rd_valid;
    logic [ENTRY_W-1:0]          rd_data;
    logic                        pop;

    // Snapshot, classify and pick next slot
    event_scanner u_event_scanner (
        .aclk               (aclk),
        .rst_n              (rst_n),
        .trans_valid        (trans_valid),
        .trans_state        (trans_state),
        .trans_addr         (trans_addr),
        .trans_channel      (trans_channel),
        .trans_event_code   (trans_event_code),
        .timeout_detected   (timeout_detected),
        .cfg_error_enable   (cfg_error_enable),
        .cfg_timeout_enable (cfg_timeout_enable),
        .cfg_compl_enable   (cfg_compl_enable),
        .reported_flags     (event_reported_flags),
        .snap_valid         (snap_valid),
        .cand_valid         (cand_valid),
        .cand_slot          (cand_slot),
        .entry_data         (entry_data)
    );

    // Push decision, reported flags, counter
    report_ctrl u_report_ctrl (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .cand_valid     (cand_valid),
        .cand_slot      (cand_slot),
        .snap_valid     (snap_valid),
        .not_full       (not_full),
        .push           (push),
        .reported_flags (event_reported_flags),
        .event_count    (event_count)
    );

    intr_fifo u_intr_fifo (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .push     (push),
        .wr_data  (entry_data),
        .pop      (pop),
        .not_full (not_full),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    // Output register and packet build
    packet_formatter u_packet_formatter (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .monbus_ready  (monbus_ready),
        .pop           (pop),
        .monbus_valid  (monbus_valid),
        .monbus_packet (monbus_packet)
    );

endmodule

/* src/packet_formatter.sv */
module packet_formatter (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            rd_valid,
    input  logic [monitor_pkg::ENTRY_W-1:0] rd_data,
    input  logic                            monbus_ready,
    output logic                            pop,
    output logic                            monbus_valid,
    output logic [63:0]                     monbus_packet
);
    import monitor_pkg::*;

    // Entry currently offered on the bus
    logic [ENTRY_W-1:0] out_entry;

    // Load when empty or when the held packet is leaving
    assign pop = rd_valid && (!monbus_valid || monbus_ready);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            monbus_valid <= 1'b0;
        end else if (pop) begin
            monbus_valid <= 1'b1;
        end else if (monbus_ready) begin
            // Transfer done and nothing queued
            monbus_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            out_entry <= rd_data;
        end
    end

    // Entry fields plus the fixed source fields
    always_comb begin
        monbus_packet[PKT_TYPE_HI:PKT_TYPE_LO]   = out_entry[ENT_TYPE_LO +: TYPE_W];
        monbus_packet[PKT_PROTO_HI:PKT_PROTO_LO] = PROTOCOL_AXI;
        monbus_packet[PKT_CODE_HI:PKT_CODE_LO]   = out_entry[ENT_CODE_LO +: CODE_W];
        monbus_packet[PKT_CHAN_HI:PKT_CHAN_LO]   = out_entry[ENT_CHAN_LO +: CHAN_W];
        monbus_packet[PKT_UNIT_HI:PKT_UNIT_LO]   = UNIT_ID;
        monbus_packet[PKT_AGENT_HI:PKT_AGENT_LO] = AGENT_ID;
        monbus_packet[PKT_DATA_HI:PKT_DATA_LO]   = out_entry[ENT_DATA_LO +: DATA_W];
    end

endmodule

/* intr_fifo/intr_fifo.sv */
module intr_fifo (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            push,
    input  logic [monitor_pkg::ENTRY_W-1:0] wr_data,
    input  logic                            pop,
    output logic                            not_full,
    output logic                            rd_valid,
    output logic [monitor_pkg::ENTRY_W-1:0] rd_data
);
    import monitor_pkg::*;

    // Entry storage
    logic [ENTRY_W-1:0] mem [INTR_FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]      count;

    logic wr_en;
    logic rd_en;

    // Guard both sides against overflow and underflow
    assign wr_en = push && not_full;
    assign rd_en = pop && rd_valid;

    assign not_full = (count != CNT_W'(INTR_FIFO_DEPTH));
    assign rd_valid = (count != '0);

    // Head entry straight from storage
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Power-of-two depth, pointers wrap on their own
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, unchanged on simultaneous push and pop
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/report_ctrl.sv */
module report_ctrl (
    input  logic                                     aclk,
    input  logic                                     rst_n,
    input  logic                                     cand_valid,
    input  logic [monitor_pkg::SLOT_W-1:0]           cand_slot,
    input  logic [monitor_pkg::MAX_TRANSACTIONS-1:0] snap_valid,
    input  logic                                     not_full,
    output logic                                     push,
    output logic [monitor_pkg::MAX_TRANSACTIONS-1:0] reported_flags,
    output logic [monitor_pkg::EVT_CNT_W-1:0]        event_count
);
    import monitor_pkg::*;

    // Candidate goes in whenever the FIFO has room
    assign push = cand_valid && not_full;

    // One flag per slot occupancy
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            reported_flags <= '0;
        end else begin
            for (int i = 0; i < MAX_TRANSACTIONS; i++) begin
                if (!snap_valid[i]) begin
                    // Slot freed, so the next occupant can report
                    reported_flags[i] <= 1'b0;
                end else if (push && cand_slot == SLOT_W'(i)) begin
                    reported_flags[i] <= 1'b1;
                end
            end
        end
    end

    // Total pushes, wraps at the top
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            event_count <= '0;
        end else if (push) begin
            event_count <= event_count + 1'b1;
        end
    end

endmodule

/* event_scan/event_scanner.sv */
module event_scanner (
    input  logic                                                            aclk,
    input  logic                                                            rst_n,
    input  logic [monitor_pkg::MAX_TRANSACTIONS-1:0]                        trans_valid,
    input  logic [monitor_pkg::MAX_TRANSACTIONS*monitor_pkg::STATE_W-1:0]   trans_state,
    input  logic [monitor_pkg::MAX_TRANSACTIONS*monitor_pkg::ADDR_WIDTH-1:0] trans_addr,
    input  logic [monitor_pkg::MAX_TRANSACTIONS*monitor_pkg::CHAN_W-1:0]    trans_channel,
    input  logic [monitor_pkg::MAX_TRANSACTIONS*monitor_pkg::CODE_W-1:0]    trans_event_code,
    input  logic [monitor_pkg::MAX_TRANSACTIONS-1:0]                        timeout_detected,
    input  logic                                                            cfg_error_enable,
    input  logic                                                            cfg_timeout_enable,
    input  logic                                                            cfg_compl_enable,
    input  logic [monitor_pkg::MAX_TRANSACTIONS-1:0]                        reported_flags,
    output logic [monitor_pkg::MAX_TRANSACTIONS-1:0]                        snap_valid,
    output logic                                                            cand_valid,
    output logic [monitor_pkg::SLOT_W-1:0]                                  cand_slot,
    output logic [monitor_pkg::ENTRY_W-1:0]                                 entry_data
);
    import monitor_pkg::*;

    // Registered copy of the table
    logic [MAX_TRANSACTIONS*STATE_W-1:0]    snap_state;
    logic [MAX_TRANSACTIONS*ADDR_WIDTH-1:0] snap_addr;
    logic [MAX_TRANSACTIONS*CHAN_W-1:0]     snap_chan;
    logic [MAX_TRANSACTIONS*CODE_W-1:0]     snap_code;
    logic [MAX_TRANSACTIONS-1:0]            snap_timeout;

    // Per-slot views of the snapshot
    logic [STATE_W-1:0]    slot_state [MAX_TRANSACTIONS];
    logic [ADDR_WIDTH-1:0] slot_addr  [MAX_TRANSACTIONS];
    logic [CHAN_W-1:0]     slot_chan  [MAX_TRANSACTIONS];
    logic [CODE_W-1:0]     slot_code  [MAX_TRANSACTIONS];

    // Event class hit vectors
    logic [MAX_TRANSACTIONS-1:0] err_vec;
    logic [MAX_TRANSACTIONS-1:0] tmo_vec;
    logic [MAX_TRANSACTIONS-1:0] cmp_vec;

    logic              err_hit;
    logic              tmo_hit;
    logic              cmp_hit;
    logic [SLOT_W-1:0] err_idx;
    logic [SLOT_W-1:0] tmo_idx;
    logic [SLOT_W-1:0] cmp_idx;
    logic [TYPE_W-1:0] sel_type;
    logic [CODE_W-1:0] sel_code;

    // Only the valid bits are control state
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            snap_valid <= '0;
        end else begin
            snap_valid <= trans_valid;
        end
    end

    always_ff @(posedge aclk) begin
        snap_state   <= trans_state;
        snap_addr    <= trans_addr;
        snap_chan    <= trans_channel;
        snap_code    <= trans_event_code;
        snap_timeout <= timeout_detected;
    end

    for (genvar i = 0; i < MAX_TRANSACTIONS; i++) begin : g_slot
        assign slot_state[i] = snap_state[i*STATE_W +: STATE_W];
        assign slot_addr[i]  = snap_addr[i*ADDR_WIDTH +: ADDR_WIDTH];
        assign slot_chan[i]  = snap_chan[i*CHAN_W +: CHAN_W];
        assign slot_code[i]  = snap_code[i*CODE_W +: CODE_W];

        // Orphans count as errors; an error with a timeout is a timeout
        assign err_vec[i] = snap_valid[i] && !reported_flags[i] && cfg_error_enable &&
                            ((slot_state[i] == TRANS_ERROR && !snap_timeout[i]) ||
                             slot_state[i] == TRANS_ORPHANED);
        assign tmo_vec[i] = snap_valid[i] && !reported_flags[i] && cfg_timeout_enable &&
                            slot_state[i] == TRANS_ERROR && snap_timeout[i];
        assign cmp_vec[i] = snap_valid[i] && !reported_flags[i] && cfg_compl_enable &&
                            slot_state[i] == TRANS_COMPLETE;
    end

    // Walk downward so the lowest set slot is kept
    always_comb begin
        err_hit = 1'b0;
        tmo_hit = 1'b0;
        cmp_hit = 1'b0;
        err_idx = '0;
        tmo_idx = '0;
        cmp_idx = '0;
        for (int i = MAX_TRANSACTIONS - 1; i >= 0; i--) begin
            if (err_vec[i]) begin
                err_hit = 1'b1;
                err_idx = SLOT_W'(i);
            end
            if (tmo_vec[i]) begin
                tmo_hit = 1'b1;
                tmo_idx = SLOT_W'(i);
            end
            if (cmp_vec[i]) begin
                cmp_hit = 1'b1;
                cmp_idx = SLOT_W'(i);
            end
        end
    end

    // Class priority: error, then timeout, then completion
    always_comb begin
        cand_valid = err_hit || tmo_hit || cmp_hit;
        if (err_hit) begin
            cand_slot = err_idx;
            sel_type  = PKT_ERROR;
            sel_code  = slot_code[err_idx];
        end else if (tmo_hit) begin
            cand_slot = tmo_idx;
            sel_type  = PKT_TIMEOUT;
            sel_code  = slot_code[tmo_idx];
        end else begin
            cand_slot = cmp_idx;
            sel_type  = PKT_COMPLETION;
            sel_code  = EVT_TRANS_COMPLETE;
        end
    end

    // Address zero-extended into the data field
    assign entry_data = {sel_type, sel_code, slot_chan[cand_slot],
                         {(DATA_W - ADDR_WIDTH){1'b0}}, slot_addr[cand_slot]};

endmodule

/* common/monitor_pkg.sv */
package monitor_pkg;

    // Transaction table geometry
    localparam int MAX_TRANSACTIONS = 16;
    localparam int SLOT_W           = 4;
    localparam int ADDR_WIDTH       = 32;
    localparam int CHAN_W           = 6;
    localparam int CODE_W           = 4;
    localparam int STATE_W          = 3;

    // Report entry layout, type then code then channel then data
    localparam int TYPE_W      = 4;
    localparam int DATA_W      = 35;
    localparam int ENTRY_W     = TYPE_W + CODE_W + CHAN_W + DATA_W;
    localparam int ENT_DATA_LO = 0;
    localparam int ENT_CHAN_LO = ENT_DATA_LO + DATA_W;
    localparam int ENT_CODE_LO = ENT_CHAN_LO + CHAN_W;
    localparam int ENT_TYPE_LO = ENT_CODE_LO + CODE_W;

    // Interrupt FIFO sizing
    localparam int INTR_FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W      = 2;
    localparam int CNT_W           = 3;

    localparam int EVT_CNT_W = 16;

    // Source identification carried in every packet
    localparam logic [3:0] UNIT_ID  = 4'd9;
    localparam logic [7:0] AGENT_ID = 8'd99;

    // Table states
    localparam logic [STATE_W-1:0] TRANS_IDLE     = 3'd0;
    localparam logic [STATE_W-1:0] TRANS_ACTIVE   = 3'd1;
    localparam logic [STATE_W-1:0] TRANS_COMPLETE = 3'd2;
    localparam logic [STATE_W-1:0] TRANS_ERROR    = 3'd3;
    localparam logic [STATE_W-1:0] TRANS_ORPHANED = 3'd4;

    // Packet type codes
    localparam logic [TYPE_W-1:0] PKT_ERROR      = 4'd0;
    localparam logic [TYPE_W-1:0] PKT_COMPLETION = 4'd1;
    localparam logic [TYPE_W-1:0] PKT_TIMEOUT    = 4'd2;

    localparam logic [CODE_W-1:0] EVT_TRANS_COMPLETE = 4'd0;
    localparam logic [2:0]        PROTOCOL_AXI       = 3'd0;

    // 64-bit monitor bus packet fields
    localparam int PKT_TYPE_HI  = 63;
    localparam int PKT_TYPE_LO  = 60;
    localparam int PKT_PROTO_HI = 59;
    localparam int PKT_PROTO_LO = 57;
    localparam int PKT_CODE_HI  = 56;
    localparam int PKT_CODE_LO  = 53;
    localparam int PKT_CHAN_HI  = 52;
    localparam int PKT_CHAN_LO  = 47;
    localparam int PKT_UNIT_HI  = 46;
    localparam int PKT_UNIT_LO  = 43;
    localparam int PKT_AGENT_HI = 42;
    localparam int PKT_AGENT_LO = 35;
    localparam int PKT_DATA_HI  = 34;
    localparam int PKT_DATA_LO  = 0;

endpackage
